/* hw/axi_burst_pkg.sv */
/*
 * AXI burst subsystem definitions
 * Bus and memory sizes, opcode, burst and response codes,
 * the queued command word and the state types of both FSMs
 */
package axi_burst_pkg;

	localparam int ADDR_W     = 16;
	localparam int DATA_W     = 32;
	localparam int STRB_W     = DATA_W / 8;
	localparam int ID_W       = 4;
	localparam int LEN_W      = 8;
	localparam int MAX_BEATS  = 16;  // Largest burst in use
	localparam int MEM_WORDS  = 256; // Bytes 0 to 1023
	localparam int CMD_DEPTH  = 4;
	localparam int BEAT_BYTES = 4;   // Full bus width per beat

	typedef enum logic {OP_READ, OP_WRITE} cmd_op_t;
	typedef enum logic [1:0] {BURST_FIXED = 2'd0, BURST_INCR = 2'd1} burst_kind_t;
	typedef enum logic [1:0] {RESP_OKAY = 2'd0, RESP_SLVERR = 2'd2} resp_t;

	typedef struct packed {
		cmd_op_t           op;
		logic [ID_W-1:0]   id;
		logic [ADDR_W-1:0] addr;
		logic [LEN_W-1:0]  len;   // Beats minus one
		burst_kind_t       burst;
	} burst_cmd_t;

	typedef enum logic [1:0] {M_IDLE, M_ADDR, M_DATA, M_RESP} master_state_t;
	typedef enum logic [1:0] {S_IDLE, S_WRITE, S_WRESP, S_READ} mem_state_t;

endpackage

/* hw/axi_bus_if.sv */
/*
 * AXI4 bus
 * All five channels between the burst master and the memory slave
 */
`timescale 1ns/1ps

interface axi_bus_if (input logic clk);

	// Write address
	logic [axi_burst_pkg::ID_W-1:0]   awid;
	logic [axi_burst_pkg::ADDR_W-1:0] awaddr;
	logic [axi_burst_pkg::LEN_W-1:0]  awlen;
	logic [2:0]                       awsize;
	axi_burst_pkg::burst_kind_t       awburst;
	logic                             awvalid;
	logic                             awready;
	// Write data
	logic [axi_burst_pkg::DATA_W-1:0] wdata;
	logic [axi_burst_pkg::STRB_W-1:0] wstrb;
	logic                             wlast;
	logic                             wvalid;
	logic                             wready;
	// Write response
	logic [axi_burst_pkg::ID_W-1:0]   bid;
	axi_burst_pkg::resp_t             bresp;
	logic                             bvalid;
	logic                             bready;
	// Read address
	logic [axi_burst_pkg::ID_W-1:0]   arid;
	logic [axi_burst_pkg::ADDR_W-1:0] araddr;
	logic [axi_burst_pkg::LEN_W-1:0]  arlen;
	logic [2:0]                       arsize;
	axi_burst_pkg::burst_kind_t       arburst;
	logic                             arvalid;
	logic                             arready;
	// Read data
	logic [axi_burst_pkg::ID_W-1:0]   rid;
	logic [axi_burst_pkg::DATA_W-1:0] rdata;
	axi_burst_pkg::resp_t             rresp;
	logic                             rlast;
	logic                             rvalid;
	logic                             rready;

	modport master (
		input  clk, awready, wready, bid, bresp, bvalid, arready, rid, rdata, rresp, rlast, rvalid,
		output awid, awaddr, awlen, awsize, awburst, awvalid, wdata, wstrb, wlast, wvalid,
		output bready, arid, araddr, arlen, arsize, arburst, arvalid, rready
	);

	modport slave (
		input  clk, awid, awaddr, awlen, awsize, awburst, awvalid, wdata, wstrb, wlast, wvalid,
		input  bready, arid, araddr, arlen, arsize, arburst, arvalid, rready,
		output awready, wready, bid, bresp, bvalid, arready, rid, rdata, rresp, rlast, rvalid
	);

endinterface

/* hw/burst_cmd_queue.sv */
/*
 * Burst command queue
 * Circular FIFO of burst commands with valid/ready on both sides,
 * push and pop may happen in the same cycle
 */
`timescale 1ns/1ps

module burst_cmd_queue (
	input  logic                      clk,
	input  logic                      resetn,
	input  logic                      in_valid,
	output logic                      in_ready,
	input  axi_burst_pkg::burst_cmd_t in_cmd,
	output logic                      out_valid,
	input  logic                      out_ready,
	output axi_burst_pkg::burst_cmd_t out_cmd
);

	axi_burst_pkg::burst_cmd_t entries [axi_burst_pkg::CMD_DEPTH];

	logic [$clog2(axi_burst_pkg::CMD_DEPTH)-1:0]   wr_ptr;
	logic [$clog2(axi_burst_pkg::CMD_DEPTH)-1:0]   rd_ptr;
	logic [$clog2(axi_burst_pkg::CMD_DEPTH+1)-1:0] count;
	logic push;
	logic pop;

	assign in_ready  = (count != axi_burst_pkg::CMD_DEPTH);
	assign out_valid = (count != '0);
	assign out_cmd   = entries[rd_ptr];
	assign push      = in_valid && in_ready;
	assign pop       = out_valid && out_ready;

	always_ff @(posedge clk) begin
		if (push)
			entries[wr_ptr] <= in_cmd;
	end

	always_ff @(posedge clk or negedge resetn) begin
		if (!resetn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1; // Depth is a power of two, wraps by itself
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			if (push && !pop)
				count <= count + 1'b1;
			else if (pop && !push)
				count <= count - 1'b1;
		end
	end

endmodule

/* hw/axi_burst_master.sv */
/*
 * AXI4 burst master
 * Takes one queued command at a time and runs its address, data
 * and response phases; write beats stream in from the wr port,
 * read beats leave through the beat port
 */
`timescale 1ns/1ps

module axi_burst_master (
	input  logic                             clk,
	input  logic                             resetn,
	input  logic                             cmd_valid,
	output logic                             cmd_ready,
	input  axi_burst_pkg::burst_cmd_t        cmd,
	input  logic [axi_burst_pkg::DATA_W-1:0] wr_data,
	input  logic [axi_burst_pkg::STRB_W-1:0] wr_strb,
	input  logic                             wr_valid,
	output logic                             wr_ready,
	axi_bus_if.master                        axi,
	output logic                             beat_valid,
	input  logic                             beat_ready,
	output logic [axi_burst_pkg::DATA_W-1:0] beat_data,
	output logic [axi_burst_pkg::ID_W-1:0]   beat_id,
	output axi_burst_pkg::resp_t             beat_resp,
	output logic                             beat_last,
	output logic                             done_valid,
	output logic [axi_burst_pkg::ID_W-1:0]   done_id,
	output axi_burst_pkg::resp_t             done_resp
);

	axi_burst_pkg::master_state_t state;
	axi_burst_pkg::master_state_t state_next;
	axi_burst_pkg::burst_cmd_t    cur_q;   // Command being served
	logic [axi_burst_pkg::LEN_W-1:0] beat_cnt;
	logic is_wr;
	logic in_data;
	logic w_fire;
	logic r_fire;

	assign is_wr   = (cur_q.op == axi_burst_pkg::OP_WRITE);
	assign in_data = (state == axi_burst_pkg::M_DATA);
	assign w_fire  = axi.wvalid && axi.wready;
	assign r_fire  = axi.rvalid && axi.rready;

	assign cmd_ready = (state == axi_burst_pkg::M_IDLE);

	// Address phase, same fields on AW and AR
	assign axi.awid    = cur_q.id;
	assign axi.awaddr  = cur_q.addr;
	assign axi.awlen   = cur_q.len;
	assign axi.awsize  = 3'($clog2(axi_burst_pkg::BEAT_BYTES));
	assign axi.awburst = cur_q.burst;
	assign axi.awvalid = (state == axi_burst_pkg::M_ADDR) && is_wr;
	assign axi.arid    = cur_q.id;
	assign axi.araddr  = cur_q.addr;
	assign axi.arlen   = cur_q.len;
	assign axi.arsize  = 3'($clog2(axi_burst_pkg::BEAT_BYTES));
	assign axi.arburst = cur_q.burst;
	assign axi.arvalid = (state == axi_burst_pkg::M_ADDR) && !is_wr;

	// Write beats pass straight through
	assign axi.wdata  = wr_data;
	assign axi.wstrb  = wr_strb;
	assign axi.wvalid = in_data && is_wr && wr_valid;
	assign axi.wlast  = in_data && (beat_cnt == cur_q.len);
	assign wr_ready   = in_data && is_wr && axi.wready;

	assign axi.bready = (state == axi_burst_pkg::M_RESP);
	assign done_valid = axi.bvalid && axi.bready; // One cycle, on the B transfer
	assign done_id    = axi.bid;
	assign done_resp  = axi.bresp;

	// Read beats forwarded with the buffer's back-pressure
	assign axi.rready = in_data && !is_wr && beat_ready;
	assign beat_valid = in_data && !is_wr && axi.rvalid;
	assign beat_data  = axi.rdata;
	assign beat_id    = axi.rid;
	assign beat_resp  = axi.rresp;
	assign beat_last  = axi.rlast;

	always_comb begin
		state_next = state;
		case (state)
			axi_burst_pkg::M_IDLE:
				if (cmd_valid)
					state_next = axi_burst_pkg::M_ADDR;
			axi_burst_pkg::M_ADDR:
				if ((axi.awvalid && axi.awready) || (axi.arvalid && axi.arready))
					state_next = axi_burst_pkg::M_DATA;
			axi_burst_pkg::M_DATA:
				if (is_wr && w_fire && axi.wlast)
					state_next = axi_burst_pkg::M_RESP;
				else if (!is_wr && r_fire && axi.rlast)
					state_next = axi_burst_pkg::M_IDLE;
			axi_burst_pkg::M_RESP:
				if (axi.bvalid)
					state_next = axi_burst_pkg::M_IDLE;
			default: state_next = axi_burst_pkg::M_IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (cmd_valid && cmd_ready)
			cur_q <= cmd;
	end

	always_ff @(posedge clk or negedge resetn) begin
		if (!resetn) begin
			state    <= axi_burst_pkg::M_IDLE;
			beat_cnt <= '0;
		end else begin
			state <= state_next;
			if (state == axi_burst_pkg::M_ADDR)
				beat_cnt <= '0;
			else if (in_data && w_fire)
				beat_cnt <= beat_cnt + 1'b1; // Counts only accepted write beats
		end
	end

endmodule

/* hw/axi_burst_memory.sv */
/*
 * AXI4 memory slave
 * 256 words, INCR and FIXED bursts, byte strobes, one burst at a time;
 * beats outside the array answer SLVERR
 */
`timescale 1ns/1ps

module axi_burst_memory (
	input  logic     clk,
	input  logic     resetn,
	axi_bus_if.slave axi
);

	logic [axi_burst_pkg::DATA_W-1:0] mem [axi_burst_pkg::MEM_WORDS];

	axi_burst_pkg::mem_state_t       state;
	logic [axi_burst_pkg::ID_W-1:0]  id_q;
	logic [axi_burst_pkg::ADDR_W-1:0] widx;    // Word index of the current beat
	logic [axi_burst_pkg::LEN_W-1:0] len_q;
	logic [axi_burst_pkg::LEN_W-1:0] rd_cnt;
	axi_burst_pkg::burst_kind_t      burst_q;
	logic err_q;
	logic in_range;
	logic aw_fire;
	logic ar_fire;
	logic w_fire;
	logic r_fire;

	assign in_range = (widx < axi_burst_pkg::MEM_WORDS);

	// Waiting write wins over a read
	assign axi.awready = (state == axi_burst_pkg::S_IDLE) && axi.awvalid;
	assign axi.arready = (state == axi_burst_pkg::S_IDLE) && axi.arvalid && !axi.awvalid;
	assign aw_fire     = axi.awvalid && axi.awready;
	assign ar_fire     = axi.arvalid && axi.arready;

	assign axi.wready = (state == axi_burst_pkg::S_WRITE);
	assign w_fire     = axi.wvalid && axi.wready;

	assign axi.bvalid = (state == axi_burst_pkg::S_WRESP);
	assign axi.bid    = id_q;
	assign axi.bresp  = err_q ? axi_burst_pkg::RESP_SLVERR : axi_burst_pkg::RESP_OKAY;

	assign axi.rvalid = (state == axi_burst_pkg::S_READ);
	assign axi.rid    = id_q;
	assign axi.rdata  = in_range ? mem[widx[$clog2(axi_burst_pkg::MEM_WORDS)-1:0]] : '0;
	assign axi.rresp  = in_range ? axi_burst_pkg::RESP_OKAY : axi_burst_pkg::RESP_SLVERR;
	assign axi.rlast  = (rd_cnt == len_q);
	assign r_fire     = axi.rvalid && axi.rready;

	always_ff @(posedge clk) begin
		if (w_fire && in_range) begin
			for (int b = 0; b < axi_burst_pkg::STRB_W; b++)
				if (axi.wstrb[b])
					mem[widx[$clog2(axi_burst_pkg::MEM_WORDS)-1:0]][8*b +: 8] <= axi.wdata[8*b +: 8];
		end
	end

	// Burst context, INCR steps one word per beat
	always_ff @(posedge clk) begin
		if (aw_fire) begin
			id_q    <= axi.awid;
			widx    <= axi.awaddr >> $clog2(axi_burst_pkg::BEAT_BYTES);
			len_q   <= axi.awlen;
			burst_q <= axi.awburst;
		end else if (ar_fire) begin
			id_q    <= axi.arid;
			widx    <= axi.araddr >> $clog2(axi_burst_pkg::BEAT_BYTES);
			len_q   <= axi.arlen;
			burst_q <= axi.arburst;
		end else if ((w_fire || r_fire) && burst_q == axi_burst_pkg::BURST_INCR) begin
			widx <= widx + 1'b1;
		end
	end

	always_ff @(posedge clk or negedge resetn) begin
		if (!resetn) begin
			state  <= axi_burst_pkg::S_IDLE;
			rd_cnt <= '0;
			err_q  <= 1'b0;
		end else begin
			case (state)
				axi_burst_pkg::S_IDLE: begin
					rd_cnt <= '0;
					err_q  <= 1'b0;
					if (aw_fire)
						state <= axi_burst_pkg::S_WRITE;
					else if (ar_fire)
						state <= axi_burst_pkg::S_READ;
				end
				axi_burst_pkg::S_WRITE:
					if (w_fire) begin
						if (!in_range)
							err_q <= 1'b1; // Sticky for the whole burst
						if (axi.wlast)
							state <= axi_burst_pkg::S_WRESP;
					end
				axi_burst_pkg::S_WRESP:
					if (axi.bready)
						state <= axi_burst_pkg::S_IDLE;
				axi_burst_pkg::S_READ:
					if (r_fire) begin
						rd_cnt <= rd_cnt + 1'b1;
						if (axi.rlast)
							state <= axi_burst_pkg::S_IDLE;
					end
				default: state <= axi_burst_pkg::S_IDLE;
			endcase
		end
	end

endmodule

/* hw/read_return_buffer.sv */
/*
 * Read return buffer
 * Two-entry skid buffer between the master's beat port and the
 * read stream; in_ready comes from a register only
 */
`timescale 1ns/1ps

module read_return_buffer (
	input  logic                             clk,
	input  logic                             resetn,
	input  logic                             in_valid,
	output logic                             in_ready,
	input  logic [axi_burst_pkg::DATA_W-1:0] in_data,
	input  logic [axi_burst_pkg::ID_W-1:0]   in_id,
	input  axi_burst_pkg::resp_t             in_resp,
	input  logic                             in_last,
	output logic                             out_valid,
	input  logic                             out_ready,
	output logic [axi_burst_pkg::DATA_W-1:0] out_data,
	output logic [axi_burst_pkg::ID_W-1:0]   out_id,
	output axi_burst_pkg::resp_t             out_resp,
	output logic                             out_last
);

	logic                             skid_valid;
	logic [axi_burst_pkg::DATA_W-1:0] skid_data;
	logic [axi_burst_pkg::ID_W-1:0]   skid_id;
	axi_burst_pkg::resp_t             skid_resp;
	logic                             skid_last;
	logic in_fire;
	logic main_free;

	assign in_ready  = !skid_valid; // Skid holds a beat only when the main entry is full
	assign in_fire   = in_valid && in_ready;
	assign main_free = !out_valid || out_ready;

	always_ff @(posedge clk) begin
		if (main_free && skid_valid) begin
			out_data <= skid_data;
			out_id   <= skid_id;
			out_resp <= skid_resp;
			out_last <= skid_last;
		end else if (main_free && in_fire) begin
			out_data <= in_data;
			out_id   <= in_id;
			out_resp <= in_resp;
			out_last <= in_last;
		end
		if (!main_free && in_fire) begin
			skid_data <= in_data;
			skid_id   <= in_id;
			skid_resp <= in_resp;
			skid_last <= in_last;
		end
	end

	always_ff @(posedge clk or negedge resetn) begin
		if (!resetn) begin
			out_valid  <= 1'b0;
			skid_valid <= 1'b0;
		end else if (main_free) begin
			out_valid  <= skid_valid || in_fire;
			skid_valid <= 1'b0;
		end else if (in_fire) begin
			skid_valid <= 1'b1; // Output stalled, park the beat
		end
	end

endmodule

/* hw/axi_burst_top.sv */
/*
 * AXI burst subsystem top
 * Command queue, burst master, read return buffer and memory slave
 * joined by one AXI4 bus
 */
`timescale 1ns/1ps

module axi_burst_top (
	input  logic                             clk,
	input  logic                             resetn,
	input  logic                             cmd_valid,
	output logic                             cmd_ready,
	input  axi_burst_pkg::cmd_op_t           cmd_op,
	input  logic [axi_burst_pkg::ID_W-1:0]   cmd_id,
	input  logic [axi_burst_pkg::ADDR_W-1:0] cmd_addr,
	input  logic [axi_burst_pkg::LEN_W-1:0]  cmd_len,
	input  axi_burst_pkg::burst_kind_t       cmd_burst,
	input  logic [axi_burst_pkg::DATA_W-1:0] wr_data,
	input  logic [axi_burst_pkg::STRB_W-1:0] wr_strb,
	input  logic                             wr_valid,
	output logic                             wr_ready,
	output logic [axi_burst_pkg::DATA_W-1:0] rd_data,
	output logic [axi_burst_pkg::ID_W-1:0]   rd_id,
	output axi_burst_pkg::resp_t             rd_resp,
	output logic                             rd_last,
	output logic                             rd_valid,
	input  logic                             rd_ready,
	output logic                             done_valid,
	output logic [axi_burst_pkg::ID_W-1:0]   done_id,
	output axi_burst_pkg::resp_t             done_resp
);

	axi_burst_pkg::burst_cmd_t        cmd_in;
	axi_burst_pkg::burst_cmd_t        q_cmd;
	logic                             q_valid;
	logic                             q_ready;
	logic                             beat_valid;
	logic                             beat_ready;
	logic [axi_burst_pkg::DATA_W-1:0] beat_data;
	logic [axi_burst_pkg::ID_W-1:0]   beat_id;
	axi_burst_pkg::resp_t             beat_resp;
	logic                             beat_last;

	assign cmd_in = '{op: cmd_op, id: cmd_id, addr: cmd_addr, len: cmd_len, burst: cmd_burst};

	axi_bus_if u_axi (.clk(clk));

	burst_cmd_queue u_queue (
		.clk(clk), .resetn(resetn),
		.in_valid(cmd_valid), .in_ready(cmd_ready), .in_cmd(cmd_in),
		.out_valid(q_valid), .out_ready(q_ready), .out_cmd(q_cmd)
	);

	axi_burst_master u_master (
		.clk(clk), .resetn(resetn),
		.cmd_valid(q_valid), .cmd_ready(q_ready), .cmd(q_cmd),
		.wr_data(wr_data), .wr_strb(wr_strb), .wr_valid(wr_valid), .wr_ready(wr_ready),
		.axi(u_axi.master),
		.beat_valid(beat_valid), .beat_ready(beat_ready), .beat_data(beat_data),
		.beat_id(beat_id), .beat_resp(beat_resp), .beat_last(beat_last),
		.done_valid(done_valid), .done_id(done_id), .done_resp(done_resp)
	);

	read_return_buffer u_return (
		.clk(clk), .resetn(resetn),
		.in_valid(beat_valid), .in_ready(beat_ready), .in_data(beat_data),
		.in_id(beat_id), .in_resp(beat_resp), .in_last(beat_last),
		.out_valid(rd_valid), .out_ready(rd_ready), .out_data(rd_data),
		.out_id(rd_id), .out_resp(rd_resp), .out_last(rd_last)
	);

	axi_burst_memory u_mem (.clk(clk), .resetn(resetn), .axi(u_axi.slave));

endmodule

/* testbench/axi_burst_sva.sv */
/*
 * AXI burst master protocol checks
 * Address exclusivity, payload stability under stall,
 * wlast placement and the one-cycle completion pulse
 */
`timescale 1ns/1ps

module axi_burst_sva (
	input logic                             clk,
	input logic                             resetn,
	input axi_burst_pkg::master_state_t     state,
	input logic                             awvalid,
	input logic                             awready,
	input logic [axi_burst_pkg::ADDR_W-1:0] awaddr,
	input logic [axi_burst_pkg::LEN_W-1:0]  awlen,
	input logic                             arvalid,
	input logic                             arready,
	input logic [axi_burst_pkg::ADDR_W-1:0] araddr,
	input logic [axi_burst_pkg::LEN_W-1:0]  arlen,
	input logic                             wvalid,
	input logic                             wready,
	input logic [axi_burst_pkg::DATA_W-1:0] wdata,
	input logic                             wlast,
	input logic                             done_valid
);

	logic [axi_burst_pkg::LEN_W-1:0] w_beats; // W transfers since the AW handshake
	logic [axi_burst_pkg::LEN_W-1:0] w_len;

	always_ff @(posedge clk or negedge resetn) begin
		if (!resetn) begin
			w_beats <= '0;
			w_len   <= '0;
		end else if (awvalid && awready) begin
			w_beats <= '0;
			w_len   <= awlen;
		end else if (wvalid && wready) begin
			w_beats <= w_beats + 1'b1;
		end
	end

	a_addr_excl: assert property (@(posedge clk) disable iff (!resetn) !(awvalid && arvalid))
		else $error("awvalid and arvalid high in the same cycle");

	// Held address must not move
	a_aw_stable: assert property (@(posedge clk) disable iff (!resetn)
		awvalid && !awready |=> awvalid && $stable(awaddr) && $stable(awlen))
		else $error("AW payload changed while stalled");

	a_ar_stable: assert property (@(posedge clk) disable iff (!resetn)
		arvalid && !arready |=> arvalid && $stable(araddr) && $stable(arlen))
		else $error("AR payload changed while stalled");

	a_w_stable: assert property (@(posedge clk) disable iff (!resetn)
		wvalid && !wready |=> wvalid && $stable(wdata))
		else $error("W payload changed while stalled");

	// Last flag belongs on beat awlen of the data phase
	a_wlast_state: assert property (@(posedge clk) disable iff (!resetn)
		wvalid && wready |-> state == axi_burst_pkg::M_DATA && wlast == (w_beats == w_len))
		else $error("wlast not on the last beat of the data phase");

	a_done_pulse: assert property (@(posedge clk) disable iff (!resetn) done_valid |=> !done_valid)
		else $error("done_valid longer than one cycle");

endmodule

bind axi_burst_master axi_burst_sva u_sva (
	.clk(clk), .resetn(resetn), .state(state),
	.awvalid(axi.awvalid), .awready(axi.awready), .awaddr(axi.awaddr), .awlen(axi.awlen),
	.arvalid(axi.arvalid), .arready(axi.arready), .araddr(axi.araddr), .arlen(axi.arlen),
	.wvalid(axi.wvalid), .wready(axi.wready), .wdata(axi.wdata), .wlast(axi.wlast),
	.done_valid(done_valid)
);

/* testbench/axi_burst_tb.sv */
/*
 * AXI burst subsystem testbench
 * Streams a command table through the DUT and predicts read beats
 * and write completions from a reference memory model
 */
`timescale 1ns/1ps

module axi_burst_tb;

	localparam int TIMEOUT = 2000; // Cycles allowed per wait

	typedef struct {
		axi_burst_pkg::cmd_op_t           op;
		logic [axi_burst_pkg::ID_W-1:0]   id;
		logic [axi_burst_pkg::ADDR_W-1:0] addr;
		logic [axi_burst_pkg::LEN_W-1:0]  len;
		axi_burst_pkg::burst_kind_t       burst;
		logic [axi_burst_pkg::STRB_W-1:0] strb;  // Rotated by one byte per beat
		bit                               stall; // Random rd_ready during the read
		axi_burst_pkg::resp_t             resp;  // Completion response of a write
	} entry_t;

	logic                             clk;
	logic                             resetn;
	logic                             cmd_valid;
	logic                             cmd_ready;
	axi_burst_pkg::cmd_op_t           cmd_op;
	logic [axi_burst_pkg::ID_W-1:0]   cmd_id;
	logic [axi_burst_pkg::ADDR_W-1:0] cmd_addr;
	logic [axi_burst_pkg::LEN_W-1:0]  cmd_len;
	axi_burst_pkg::burst_kind_t       cmd_burst;
	logic [axi_burst_pkg::DATA_W-1:0] wr_data;
	logic [axi_burst_pkg::STRB_W-1:0] wr_strb;
	logic                             wr_valid;
	logic                             wr_ready;
	logic [axi_burst_pkg::DATA_W-1:0] rd_data;
	logic [axi_burst_pkg::ID_W-1:0]   rd_id;
	axi_burst_pkg::resp_t             rd_resp;
	logic                             rd_last;
	logic                             rd_valid;
	logic                             rd_ready;
	logic                             done_valid;
	logic [axi_burst_pkg::ID_W-1:0]   done_id;
	axi_burst_pkg::resp_t             done_resp;

	entry_t stim [$];
	logic [axi_burst_pkg::DATA_W-1:0] ref_mem [axi_burst_pkg::MEM_WORDS];
	integer seed;

	axi_burst_top u_axi_burst_top (.*);

	always #4 clk = ~clk;

	task automatic stop_with_failure();
		$display("Errors found");
		$fatal(1);
	endtask

	task automatic check_level(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("mismatch at %0t: %s is %b, expected %b", $time, name, got, exp);
			stop_with_failure();
		end
	endtask

	task automatic check_read(input logic [axi_burst_pkg::DATA_W-1:0] exp_data,
			input logic [axi_burst_pkg::ID_W-1:0] exp_id, input axi_burst_pkg::resp_t exp_resp,
			input logic exp_last);
		if (rd_data !== exp_data || rd_id !== exp_id || rd_resp !== exp_resp ||
				rd_last !== exp_last) begin
			$display("mismatch at %0t: read beat data %h id %0d resp %s last %b", $time,
				rd_data, rd_id, rd_resp.name(), rd_last);
			$display("  expected data %h id %0d resp %s last %b", exp_data, exp_id,
				exp_resp.name(), exp_last);
			stop_with_failure();
		end
	endtask

	task automatic check_done(input logic [axi_burst_pkg::ID_W-1:0] exp_id,
			input axi_burst_pkg::resp_t exp_resp);
		if (done_id !== exp_id || done_resp !== exp_resp) begin
			$display("mismatch at %0t: completion id %0d resp %s, expected id %0d resp %s",
				$time, done_id, done_resp.name(), exp_id, exp_resp.name());
			stop_with_failure();
		end
	endtask

	task automatic check_idle_outputs();
		check_level("rd_valid", rd_valid, 1'b0);
		check_level("done_valid", done_valid, 1'b0);
		check_level("wr_ready", wr_ready, 1'b0);
		check_level("cmd_ready", cmd_ready, 1'b1);
	endtask

	function automatic void add_entry(axi_burst_pkg::cmd_op_t op, int id, int addr, int len,
			axi_burst_pkg::burst_kind_t burst, int strb, bit stall, axi_burst_pkg::resp_t resp);
		entry_t e;
		e.op    = op;
		e.id    = id;
		e.addr  = addr;
		e.len   = len;
		e.burst = burst;
		e.strb  = strb;
		e.stall = stall;
		e.resp  = resp;
		stim.push_back(e);
	endfunction

	function automatic logic [axi_burst_pkg::STRB_W-1:0] beat_strb(
			logic [axi_burst_pkg::STRB_W-1:0] s, int k);
		for (int j = 0; j < k % axi_burst_pkg::STRB_W; j++)
			s = {s[axi_burst_pkg::STRB_W-2:0], s[axi_burst_pkg::STRB_W-1]};
		return s;
	endfunction

	// Word hit by beat k of a burst
	function automatic int word_index(entry_t e, int k);
		if (e.burst == axi_burst_pkg::BURST_INCR)
			return e.addr / axi_burst_pkg::BEAT_BYTES + k;
		return e.addr / axi_burst_pkg::BEAT_BYTES;
	endfunction

	task automatic push_cmds();
		int cycles;
		bit got;
		foreach (stim[i]) begin
			@(negedge clk);
			cmd_op    = stim[i].op;
			cmd_id    = stim[i].id;
			cmd_addr  = stim[i].addr;
			cmd_len   = stim[i].len;
			cmd_burst = stim[i].burst;
			cmd_valid = 1'b1;
			got = 1'b0;
			cycles = 0;
			while (!got) begin
				@(posedge clk);
				got = cmd_ready;
				cycles++;
				if (!got && cycles > TIMEOUT) begin
					$display("timeout at %0t: command %0d never accepted", $time, i);
					stop_with_failure();
				end
			end
		end
		@(negedge clk);
		cmd_valid = 1'b0;
	endtask

	task automatic feed_writes();
		int cycles;
		int idx;
		bit got;
		foreach (stim[i]) begin
			if (stim[i].op == axi_burst_pkg::OP_WRITE) begin
				for (int k = 0; k <= stim[i].len; k++) begin
					@(negedge clk);
					wr_data  = $random(seed);
					wr_strb  = beat_strb(stim[i].strb, k);
					wr_valid = 1'b1;
					got = 1'b0;
					cycles = 0;
					while (!got) begin
						@(posedge clk);
						got = wr_ready;
						cycles++;
						if (!got && cycles > TIMEOUT) begin
							$display("timeout at %0t: write beat %0d of id %0d never taken",
								$time, k, stim[i].id);
							stop_with_failure();
						end
					end
					idx = word_index(stim[i], k);
					if (idx < axi_burst_pkg::MEM_WORDS) begin // Dropped beyond the array
						for (int b = 0; b < axi_burst_pkg::STRB_W; b++)
							if (wr_strb[b])
								ref_mem[idx][8*b +: 8] = wr_data[8*b +: 8];
					end
				end
				@(negedge clk);
				wr_valid = 1'b0;
			end
		end
	endtask

	task automatic collect_reads();
		int cycles;
		int idx;
		bit got;
		logic [axi_burst_pkg::DATA_W-1:0] exp_data;
		axi_burst_pkg::resp_t exp_resp;
		foreach (stim[i]) begin
			if (stim[i].op == axi_burst_pkg::OP_READ) begin
				for (int k = 0; k <= stim[i].len; k++) begin
					got = 1'b0;
					cycles = 0;
					while (!got) begin
						@(negedge clk);
						if (stim[i].stall)
							rd_ready = $random(seed);
						else
							rd_ready = 1'b1;
						@(posedge clk);
						got = rd_valid && rd_ready;
						cycles++;
						if (!got && cycles > TIMEOUT) begin
							$display("timeout at %0t: read beat %0d of id %0d never came",
								$time, k, stim[i].id);
							stop_with_failure();
						end
					end
					idx = word_index(stim[i], k);
					if (idx < axi_burst_pkg::MEM_WORDS) begin
						exp_data = ref_mem[idx];
						exp_resp = axi_burst_pkg::RESP_OKAY;
					end else begin
						exp_data = '0;
						exp_resp = axi_burst_pkg::RESP_SLVERR;
					end
					check_read(exp_data, stim[i].id, exp_resp, k == stim[i].len);
				end
			end
		end
		rd_ready = 1'b1;
	endtask

	task automatic collect_dones();
		int cycles;
		bit got;
		foreach (stim[i]) begin
			if (stim[i].op == axi_burst_pkg::OP_WRITE) begin
				got = 1'b0;
				cycles = 0;
				while (!got) begin
					@(posedge clk);
					got = done_valid;
					cycles++;
					if (!got && cycles > TIMEOUT) begin
						$display("timeout at %0t: no completion for write id %0d",
							$time, stim[i].id);
						stop_with_failure();
					end
				end
				check_done(stim[i].id, stim[i].resp);
			end
		end
	endtask

	initial begin
		clk       = 1'b0;
		resetn    = 1'b0;
		cmd_valid = 1'b0;
		cmd_op    = axi_burst_pkg::OP_READ;
		cmd_id    = '0;
		cmd_addr  = '0;
		cmd_len   = '0;
		cmd_burst = axi_burst_pkg::BURST_INCR;
		wr_data   = '0;
		wr_strb   = '0;
		wr_valid  = 1'b0;
		rd_ready  = 1'b1;
		seed      = 32'h1c04;
		foreach (ref_mem[i])
			ref_mem[i] = '0;

		// INCR round trip, FIXED with strobes, range errors
		add_entry(axi_burst_pkg::OP_WRITE, 1, 'h040, 7, axi_burst_pkg::BURST_INCR,
			'hF, 0, axi_burst_pkg::RESP_OKAY);
		add_entry(axi_burst_pkg::OP_READ, 2, 'h040, 7, axi_burst_pkg::BURST_INCR,
			'hF, 0, axi_burst_pkg::RESP_OKAY);
		add_entry(axi_burst_pkg::OP_WRITE, 3, 'h100, 3, axi_burst_pkg::BURST_FIXED,
			'h1, 0, axi_burst_pkg::RESP_OKAY);
		add_entry(axi_burst_pkg::OP_READ, 4, 'h100, 3, axi_burst_pkg::BURST_FIXED,
			'hF, 0, axi_burst_pkg::RESP_OKAY);
		add_entry(axi_burst_pkg::OP_WRITE, 5, 1016, 3, axi_burst_pkg::BURST_INCR,
			'hF, 0, axi_burst_pkg::RESP_SLVERR);
		add_entry(axi_burst_pkg::OP_READ, 6, 1016, 3, axi_burst_pkg::BURST_INCR,
			'hF, 0, axi_burst_pkg::RESP_OKAY);
		// Queued back to back with read stalls
		add_entry(axi_burst_pkg::OP_WRITE, 7, 'h200, 15, axi_burst_pkg::BURST_INCR,
			'hF, 0, axi_burst_pkg::RESP_OKAY);
		add_entry(axi_burst_pkg::OP_READ, 8, 'h200, 15, axi_burst_pkg::BURST_INCR,
			'hF, 1, axi_burst_pkg::RESP_OKAY);
		add_entry(axi_burst_pkg::OP_WRITE, 9, 'h300, 5, axi_burst_pkg::BURST_INCR,
			'hF, 0, axi_burst_pkg::RESP_OKAY);
		add_entry(axi_burst_pkg::OP_READ, 10, 'h300, 5, axi_burst_pkg::BURST_INCR,
			'hF, 1, axi_burst_pkg::RESP_OKAY);

		repeat (5) @(negedge clk);
		check_idle_outputs(); // Inside reset
		repeat (5) @(negedge clk);
		resetn = 1'b1;
		@(negedge clk);
		check_idle_outputs();

		fork
			push_cmds();
			feed_writes();
			collect_reads();
			collect_dones();
		join

		repeat (4) @(negedge clk);
		$display("No errors");
		$finish;
	end

endmodule

/* files.f */
hw/axi_burst_pkg.sv
hw/axi_bus_if.sv
hw/burst_cmd_queue.sv
hw/axi_burst_master.sv
hw/axi_burst_memory.sv
hw/read_return_buffer.sv
hw/axi_burst_top.sv
testbench/axi_burst_sva.sv
testbench/axi_burst_tb.sv
